//--- logic/rv_decode_settings.svh
`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

// ============================================================
// datapath widths
// ============================================================

// register file data and immediate width
`define RV_XLEN 64

// fetched instruction word
`define RV_INST_W 32

// gpr index width, 32 registers
`define RV_REG_ADDR_W 5

`endif

//--- logic/rv_decode_pkg.sv
`default_nettype none

`include "rv_decode_settings.svh"

package rv_decode_pkg;

    // ============================================================
    // major opcodes of the kept instruction set
    // ============================================================
    typedef enum logic [6:0] {
        OP_IMM    = 7'b0010011,
        OP_IMM_32 = 7'b0011011,
        OP        = 7'b0110011,
        OP_32     = 7'b0111011,
        LOAD      = 7'b0000011,
        STORE     = 7'b0100011,
        BRANCH    = 7'b1100011,
        JAL       = 7'b1101111,
        JALR      = 7'b1100111,
        AUIPC     = 7'b0010111,
        LUI       = 7'b0110111
    } opcode_e;

    // pass forwards operand 2 unchanged
    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_MUL, ALU_MULH, ALU_MULHSU,
        ALU_MULHU, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU, ALU_PASS
    } alu_op_e;

    typedef enum logic [1:0] {SRC1_RS1, SRC1_PC} src1_e;

    typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR} src2_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_cond_e;

    // conditional branches share pc relative targets with jal
    typedef enum logic [1:0] {JUMP_NONE, JUMP_PC_IMM, JUMP_RS1_IMM} jump_e;

    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD, MEM_DWORD} mem_size_e;

    typedef enum logic [2:0] {IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_fmt_e;

    // ============================================================
    // decoded result, payload of the output stage
    // ============================================================
    typedef struct packed {
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        alu_op_e                   alu_op;
        logic                      word_op;
        src1_e                     src1;
        src2_e                     src2;
        br_cond_e                  br_cond;
        jump_e                     jump;
        logic                      load;
        logic                      store;
        mem_size_e                 mem_size;
        logic                      mem_unsigned;
        logic                      write_gpr;
        logic [`RV_XLEN-1:0]       imm;
        logic                      illegal;
    } decode_t;

endpackage

`default_nettype wire

//--- logic/rv_inst_classifier.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_settings.svh"

module rv_inst_classifier (
    input  wire logic [`RV_INST_W-1:0]  inst_i,
    output rv_decode_pkg::opcode_e      opcode_o,
    output logic [2:0]                  func3_o,
    output logic [6:0]                  func7_o,
    output logic                        is_word_o,
    output logic                        is_alu_imm_o,
    output logic                        is_alu_reg_o,
    output logic                        is_load_o,
    output logic                        is_store_o,
    output logic                        is_branch_o,
    output logic                        is_jal_o,
    output logic                        is_jalr_o,
    output logic                        is_auipc_o,
    output logic                        is_lui_o,
    output logic                        illegal_o
);

    logic legal;

    assign opcode_o = rv_decode_pkg::opcode_e'(inst_i[6:0]);
    assign func3_o  = inst_i[14:12];
    assign func7_o  = inst_i[31:25];

    // ============================================================
    // per opcode func3 / func7 legality
    // ============================================================
    always_comb begin
        legal = 1'b0;
        case (opcode_o)
            rv_decode_pkg::OP_IMM: begin
                // rv64 shamt is 6 bits so only inst[31:26] is a function field
                case (func3_o)
                    3'b001:  legal = (inst_i[31:26] == 6'b000000);
                    3'b101:  legal = (inst_i[31:26] inside {6'b000000, 6'b010000});
                    default: legal = 1'b1;
                endcase
            end
            rv_decode_pkg::OP_IMM_32: begin
                case (func3_o)
                    3'b000:  legal = 1'b1;
                    3'b001:  legal = (func7_o == 7'b0000000);
                    3'b101:  legal = (func7_o inside {7'b0000000, 7'b0100000});
                    default: legal = 1'b0;
                endcase
            end
            rv_decode_pkg::OP: begin
                legal = (func7_o inside {7'b0000000, 7'b0000001})
                      || (func7_o == 7'b0100000 && func3_o inside {3'b000, 3'b101});
            end
            rv_decode_pkg::OP_32: begin
                // word forms have no slt, logic ops or mulh variants
                case (func7_o)
                    7'b0000000: legal = func3_o inside {3'b000, 3'b001, 3'b101};
                    7'b0100000: legal = func3_o inside {3'b000, 3'b101};
                    7'b0000001: legal = (func3_o == 3'b000) || func3_o[2];
                    default:    legal = 1'b0;
                endcase
            end
            rv_decode_pkg::LOAD:   legal = (func3_o != 3'b111);
            rv_decode_pkg::STORE:  legal = !func3_o[2];
            rv_decode_pkg::BRANCH: legal = (func3_o[2:1] != 2'b01);
            rv_decode_pkg::JALR:   legal = (func3_o == 3'b000);
            rv_decode_pkg::JAL,
            rv_decode_pkg::AUIPC,
            rv_decode_pkg::LUI:    legal = 1'b1;
            // system, csr, fence and unknown opcodes
            default:               legal = 1'b0;
        endcase
    end

    assign illegal_o = !legal;

    // class flags are all cleared on an illegal encoding
    assign is_word_o    = legal && (opcode_o inside {rv_decode_pkg::OP_IMM_32,
                                                     rv_decode_pkg::OP_32});
    assign is_alu_imm_o = legal && (opcode_o inside {rv_decode_pkg::OP_IMM,
                                                     rv_decode_pkg::OP_IMM_32});
    assign is_alu_reg_o = legal && (opcode_o inside {rv_decode_pkg::OP, rv_decode_pkg::OP_32});
    assign is_load_o    = legal && (opcode_o == rv_decode_pkg::LOAD);
    assign is_store_o   = legal && (opcode_o == rv_decode_pkg::STORE);
    assign is_branch_o  = legal && (opcode_o == rv_decode_pkg::BRANCH);
    assign is_jal_o     = legal && (opcode_o == rv_decode_pkg::JAL);
    assign is_jalr_o    = legal && (opcode_o == rv_decode_pkg::JALR);
    assign is_auipc_o   = legal && (opcode_o == rv_decode_pkg::AUIPC);
    assign is_lui_o     = legal && (opcode_o == rv_decode_pkg::LUI);

    a_one_class: assert final ($onehot({illegal_o, is_alu_imm_o, is_alu_reg_o, is_load_o,
                                        is_store_o, is_branch_o, is_jal_o, is_jalr_o,
                                        is_auipc_o, is_lui_o}))
        else $error("legal instruction not decoded into exactly one class");

endmodule

`default_nettype wire

//--- logic/rv_exec_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_ctrl (
    input  wire logic [2:0]        func3_i,
    input  wire logic [6:0]        func7_i,
    input  wire logic              is_word_i,
    input  wire logic              is_alu_imm_i,
    input  wire logic              is_alu_reg_i,
    input  wire logic              is_load_i,
    input  wire logic              is_store_i,
    input  wire logic              is_jal_i,
    input  wire logic              is_jalr_i,
    input  wire logic              is_auipc_i,
    input  wire logic              is_lui_i,
    output rv_decode_pkg::alu_op_e alu_op_o,
    output logic                   word_op_o,
    output rv_decode_pkg::src1_e   src1_o,
    output rv_decode_pkg::src2_e   src2_o
);

    // word flag comes straight from the opcode class
    assign word_op_o = is_word_i;

    always_comb begin
        alu_op_o = rv_decode_pkg::ALU_ADD;
        src1_o   = rv_decode_pkg::SRC1_RS1;
        src2_o   = rv_decode_pkg::SRC2_RS2;
        if (is_alu_reg_i && func7_i[0]) begin
            // m extension, func3 picks the unit variant
            case (func3_i)
                3'b000: alu_op_o = rv_decode_pkg::ALU_MUL;
                3'b001: alu_op_o = rv_decode_pkg::ALU_MULH;
                3'b010: alu_op_o = rv_decode_pkg::ALU_MULHSU;
                3'b011: alu_op_o = rv_decode_pkg::ALU_MULHU;
                3'b100: alu_op_o = rv_decode_pkg::ALU_DIV;
                3'b101: alu_op_o = rv_decode_pkg::ALU_DIVU;
                3'b110: alu_op_o = rv_decode_pkg::ALU_REM;
                3'b111: alu_op_o = rv_decode_pkg::ALU_REMU;
            endcase
        end else if (is_alu_reg_i || is_alu_imm_i) begin
            case (func3_i)
                // addi has immediate bits in func7, only reg forms subtract
                3'b000:  alu_op_o = (is_alu_reg_i && func7_i[5]) ? rv_decode_pkg::ALU_SUB
                                                                  : rv_decode_pkg::ALU_ADD;
                3'b001:  alu_op_o = rv_decode_pkg::ALU_SLL;
                3'b010:  alu_op_o = rv_decode_pkg::ALU_SLT;
                3'b011:  alu_op_o = rv_decode_pkg::ALU_SLTU;
                3'b100:  alu_op_o = rv_decode_pkg::ALU_XOR;
                3'b101:  alu_op_o = func7_i[5] ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
                3'b110:  alu_op_o = rv_decode_pkg::ALU_OR;
                default: alu_op_o = rv_decode_pkg::ALU_AND;
            endcase
            if (is_alu_imm_i) begin
                src2_o = rv_decode_pkg::SRC2_IMM;
            end
        end else if (is_load_i || is_store_i) begin
            // effective address rs1 + imm
            src2_o = rv_decode_pkg::SRC2_IMM;
        end else if (is_jal_i || is_jalr_i) begin
            // link value pc + 4
            src1_o = rv_decode_pkg::SRC1_PC;
            src2_o = rv_decode_pkg::SRC2_FOUR;
        end else if (is_auipc_i) begin
            src1_o = rv_decode_pkg::SRC1_PC;
            src2_o = rv_decode_pkg::SRC2_IMM;
        end else if (is_lui_i) begin
            alu_op_o = rv_decode_pkg::ALU_PASS;
            src2_o   = rv_decode_pkg::SRC2_IMM;
        end else begin
            // branches compare rs1 against rs2
            alu_op_o = rv_decode_pkg::ALU_SUB;
        end
    end

endmodule

`default_nettype wire

//--- logic/rv_flow_mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rv_flow_mem_ctrl (
    input  wire logic [2:0]          func3_i,
    input  wire logic                is_load_i,
    input  wire logic                is_store_i,
    input  wire logic                is_branch_i,
    input  wire logic                is_jal_i,
    input  wire logic                is_jalr_i,
    input  wire logic                illegal_i,
    output rv_decode_pkg::br_cond_e  br_cond_o,
    output rv_decode_pkg::jump_e     jump_o,
    output logic                     load_o,
    output logic                     store_o,
    output rv_decode_pkg::mem_size_e mem_size_o,
    output logic                     mem_unsigned_o,
    output logic                     write_gpr_o
);

    // ============================================================
    // control flow
    // ============================================================
    always_comb begin
        br_cond_o = rv_decode_pkg::BR_NONE;
        if (is_branch_i) begin
            case (func3_i)
                3'b000:  br_cond_o = rv_decode_pkg::BR_EQ;
                3'b001:  br_cond_o = rv_decode_pkg::BR_NE;
                3'b100:  br_cond_o = rv_decode_pkg::BR_LT;
                3'b101:  br_cond_o = rv_decode_pkg::BR_GE;
                3'b110:  br_cond_o = rv_decode_pkg::BR_LTU;
                3'b111:  br_cond_o = rv_decode_pkg::BR_GEU;
                default: br_cond_o = rv_decode_pkg::BR_NONE;
            endcase
        end
    end

    assign jump_o = (is_jal_i || is_branch_i) ? rv_decode_pkg::JUMP_PC_IMM :
                    is_jalr_i                 ? rv_decode_pkg::JUMP_RS1_IMM :
                                                rv_decode_pkg::JUMP_NONE;

    // ============================================================
    // memory access
    // ============================================================
    assign load_o  = is_load_i;
    assign store_o = is_store_i;

    // func3[1:0] encodes the size, func3[2] the zero extension of loads
    assign mem_size_o     = (is_load_i || is_store_i) ? rv_decode_pkg::mem_size_e'(func3_i[1:0])
                                                      : rv_decode_pkg::MEM_BYTE;
    assign mem_unsigned_o = is_load_i && func3_i[2];

    assign write_gpr_o = !(is_store_i || is_branch_i || illegal_i);

endmodule

`default_nettype wire

//--- logic/rv_imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_settings.svh"

module rv_imm_gen (
    input  wire logic [`RV_INST_W-1:0] inst_i,
    input  wire logic                  is_alu_imm_i,
    input  wire logic                  is_load_i,
    input  wire logic                  is_jalr_i,
    input  wire logic                  is_store_i,
    input  wire logic                  is_branch_i,
    input  wire logic                  is_jal_i,
    input  wire logic                  is_auipc_i,
    input  wire logic                  is_lui_i,
    output logic [`RV_XLEN-1:0]        imm_o
);

    rv_decode_pkg::imm_fmt_e fmt;
    logic                    sign;

    assign sign = inst_i[31];

    // register forms and illegal encodings fall to none
    assign fmt = (is_alu_imm_i || is_load_i || is_jalr_i) ? rv_decode_pkg::IMM_I :
                 is_store_i                               ? rv_decode_pkg::IMM_S :
                 is_branch_i                              ? rv_decode_pkg::IMM_B :
                 (is_auipc_i || is_lui_i)                 ? rv_decode_pkg::IMM_U :
                 is_jal_i                                 ? rv_decode_pkg::IMM_J :
                                                            rv_decode_pkg::IMM_NONE;

    always_comb begin
        case (fmt)
            rv_decode_pkg::IMM_I: imm_o = {{(`RV_XLEN-12){sign}}, inst_i[31:20]};
            rv_decode_pkg::IMM_S: imm_o = {{(`RV_XLEN-12){sign}}, inst_i[31:25], inst_i[11:7]};
            rv_decode_pkg::IMM_B: imm_o = {{(`RV_XLEN-12){sign}}, inst_i[7], inst_i[30:25],
                                           inst_i[11:8], 1'b0};
            rv_decode_pkg::IMM_U: imm_o = {{(`RV_XLEN-32){sign}}, inst_i[31:12], 12'b0};
            rv_decode_pkg::IMM_J: imm_o = {{(`RV_XLEN-20){sign}}, inst_i[19:12], inst_i[20],
                                           inst_i[30:21], 1'b0};
            default:              imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/rv_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire logic in_valid_i,
    output logic      in_ready_o,
    input  payload_t  in_data_i,
    output logic      out_valid_o,
    input  wire logic out_ready_i,
    output payload_t  out_data_o
);

    logic     valid_q;
    payload_t data_q;

    // empty, or the held item leaves on this edge
    assign in_ready_o = !valid_q || out_ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

    // ============================================================
    // stream rules on the input side
    // ============================================================
    a_data_held: assert property (@(posedge clk_i) disable iff (rst_i)
        in_valid_i && !in_ready_o |=> $stable(in_data_i));

    a_valid_held: assert property (@(posedge clk_i) disable iff (rst_i)
        in_valid_i && !in_ready_o |=> in_valid_i);

endmodule

`default_nettype wire

//--- logic/rv_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_settings.svh"

module rv_decode_top (
    input  wire logic                     clk_i,
    input  wire logic                     rst_i,
    input  wire logic                     in_valid_i,
    output logic                          in_ready_o,
    input  wire logic [`RV_INST_W-1:0]    in_inst_i,
    output logic                          out_valid_o,
    input  wire logic                     out_ready_i,
    output logic [`RV_REG_ADDR_W-1:0]     rd_o,
    output logic [`RV_REG_ADDR_W-1:0]     rs1_o,
    output logic [`RV_REG_ADDR_W-1:0]     rs2_o,
    output rv_decode_pkg::alu_op_e        alu_op_o,
    output logic                          word_op_o,
    output rv_decode_pkg::src1_e          src1_o,
    output rv_decode_pkg::src2_e          src2_o,
    output rv_decode_pkg::br_cond_e       br_cond_o,
    output rv_decode_pkg::jump_e          jump_o,
    output logic                          load_o,
    output logic                          store_o,
    output rv_decode_pkg::mem_size_e      mem_size_o,
    output logic                          mem_unsigned_o,
    output logic                          write_gpr_o,
    output logic [`RV_XLEN-1:0]           imm_o,
    output logic                          illegal_o
);

    logic                  s1_valid;
    logic                  s2_ready;
    logic [`RV_INST_W-1:0] s1_inst;
    logic [2:0]            func3;
    logic [6:0]            func7;
    logic                  is_word, is_alu_imm, is_alu_reg, is_load, is_store;
    logic                  is_branch, is_jal, is_jalr, is_auipc, is_lui, illegal;
    rv_decode_pkg::decode_t dec_d;
    rv_decode_pkg::decode_t dec_q;

    // ============================================================
    // stage 1, instruction register
    // ============================================================
    rv_pipe_reg #(.payload_t(logic [`RV_INST_W-1:0])) i_stage1 (
        .clk_i(clk_i), .rst_i(rst_i),
        .in_valid_i(in_valid_i), .in_ready_o(in_ready_o), .in_data_i(in_inst_i),
        .out_valid_o(s1_valid), .out_ready_i(s2_ready), .out_data_o(s1_inst)
    );

    rv_inst_classifier i_classifier (
        .inst_i(s1_inst), .opcode_o(), .func3_o(func3), .func7_o(func7),
        .is_word_o(is_word), .is_alu_imm_o(is_alu_imm), .is_alu_reg_o(is_alu_reg),
        .is_load_o(is_load), .is_store_o(is_store), .is_branch_o(is_branch),
        .is_jal_o(is_jal), .is_jalr_o(is_jalr), .is_auipc_o(is_auipc),
        .is_lui_o(is_lui), .illegal_o(illegal)
    );

    rv_exec_ctrl i_exec_ctrl (
        .func3_i(func3), .func7_i(func7), .is_word_i(is_word),
        .is_alu_imm_i(is_alu_imm), .is_alu_reg_i(is_alu_reg), .is_load_i(is_load),
        .is_store_i(is_store), .is_jal_i(is_jal), .is_jalr_i(is_jalr),
        .is_auipc_i(is_auipc), .is_lui_i(is_lui), .alu_op_o(dec_d.alu_op),
        .word_op_o(dec_d.word_op), .src1_o(dec_d.src1), .src2_o(dec_d.src2)
    );

    rv_flow_mem_ctrl i_flow_mem_ctrl (
        .func3_i(func3), .is_load_i(is_load), .is_store_i(is_store),
        .is_branch_i(is_branch), .is_jal_i(is_jal), .is_jalr_i(is_jalr),
        .illegal_i(illegal), .br_cond_o(dec_d.br_cond), .jump_o(dec_d.jump),
        .load_o(dec_d.load), .store_o(dec_d.store), .mem_size_o(dec_d.mem_size),
        .mem_unsigned_o(dec_d.mem_unsigned), .write_gpr_o(dec_d.write_gpr)
    );

    rv_imm_gen i_imm_gen (
        .inst_i(s1_inst), .is_alu_imm_i(is_alu_imm), .is_load_i(is_load),
        .is_jalr_i(is_jalr), .is_store_i(is_store), .is_branch_i(is_branch),
        .is_jal_i(is_jal), .is_auipc_i(is_auipc), .is_lui_i(is_lui), .imm_o(dec_d.imm)
    );

    // register fields are raw bit ranges, whatever the format
    assign dec_d.rd      = s1_inst[11:7];
    assign dec_d.rs1     = s1_inst[19:15];
    assign dec_d.rs2     = s1_inst[24:20];
    assign dec_d.illegal = illegal;

    // ============================================================
    // stage 2, decoded result register
    // ============================================================
    rv_pipe_reg #(.payload_t(rv_decode_pkg::decode_t)) i_stage2 (
        .clk_i(clk_i), .rst_i(rst_i),
        .in_valid_i(s1_valid), .in_ready_o(s2_ready), .in_data_i(dec_d),
        .out_valid_o(out_valid_o), .out_ready_i(out_ready_i), .out_data_o(dec_q)
    );

    assign rd_o           = dec_q.rd;
    assign rs1_o          = dec_q.rs1;
    assign rs2_o          = dec_q.rs2;
    assign alu_op_o       = dec_q.alu_op;
    assign word_op_o      = dec_q.word_op;
    assign src1_o         = dec_q.src1;
    assign src2_o         = dec_q.src2;
    assign br_cond_o      = dec_q.br_cond;
    assign jump_o         = dec_q.jump;
    assign load_o         = dec_q.load;
    assign store_o        = dec_q.store;
    assign mem_size_o     = dec_q.mem_size;
    assign mem_unsigned_o = dec_q.mem_unsigned;
    assign write_gpr_o    = dec_q.write_gpr;
    assign imm_o          = dec_q.imm;
    assign illegal_o      = dec_q.illegal;

endmodule

`default_nettype wire

//--- tb/rv_decode_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_settings.svh"

module rv_decode_tb;

    localparam int CLK_PERIOD  = 8;
    localparam int DRIVE_DELAY = 1;
    localparam int TIMEOUT     = 100;
    localparam int FIELDS      = 14;
    localparam int MAX_LINES   = 64;
    localparam int READY_LOW   = 0;
    localparam int READY_HIGH  = 1;
    localparam int READY_LFSR  = 2;

    // column offsets within one stimulus line
    localparam int F_INST = 0, F_ALU = 1, F_WORD = 2, F_SRC1 = 3, F_SRC2 = 4;
    localparam int F_BR = 5, F_JUMP = 6, F_LOAD = 7, F_STORE = 8, F_SIZE = 9;
    localparam int F_UNS = 10, F_WGPR = 11, F_IMM = 12, F_ILL = 13;

    logic                      clk;
    logic                      rst;
    logic                      in_valid;
    logic                      in_ready;
    logic [`RV_INST_W-1:0]     in_inst;
    logic                      out_valid;
    logic                      out_ready;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    rv_decode_pkg::alu_op_e    alu_op;
    logic                      word_op;
    rv_decode_pkg::src1_e      src1;
    rv_decode_pkg::src2_e      src2;
    rv_decode_pkg::br_cond_e   br_cond;
    rv_decode_pkg::jump_e      jump;
    logic                      load;
    logic                      store;
    rv_decode_pkg::mem_size_e  mem_size;
    logic                      mem_unsigned;
    logic                      write_gpr;
    logic [`RV_XLEN-1:0]       imm;
    logic                      illegal;

    logic [63:0] stim_mem [0:MAX_LINES*FIELDS-1];
    logic [31:0] lfsr_state = 32'hb8e2_e63c;
    int          stim_count = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          in_flight = 0;
    int          cycle_cnt = 0;
    int          ready_mode = READY_LOW;
    int          accept_q[$];
    int          expect_q[$];
    string       cur_test = "reset";

    rv_decode_top i_rv_decode_top (
        .clk_i(clk), .rst_i(rst),
        .in_valid_i(in_valid), .in_ready_o(in_ready), .in_inst_i(in_inst),
        .out_valid_o(out_valid), .out_ready_i(out_ready),
        .rd_o(rd), .rs1_o(rs1), .rs2_o(rs2),
        .alu_op_o(alu_op), .word_op_o(word_op), .src1_o(src1), .src2_o(src2),
        .br_cond_o(br_cond), .jump_o(jump), .load_o(load), .store_o(store),
        .mem_size_o(mem_size), .mem_unsigned_o(mem_unsigned),
        .write_gpr_o(write_gpr), .imm_o(imm), .illegal_o(illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
    end

    // ============================================================
    // helpers
    // ============================================================
    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    task automatic check_field(input string test, input string field,
                               input logic [63:0] expected, input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error %s %s: expected %0h, actual %0h", test, field, expected, actual);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $finish;
    endtask

    // ready for the output side, one lfsr bit per cycle when stalling
    always @(posedge clk) begin
        #DRIVE_DELAY;
        if (ready_mode == READY_LFSR) begin
            lfsr_state = lfsr_step(lfsr_state);
            out_ready  = lfsr_state[0];
        end else begin
            out_ready = (ready_mode == READY_HIGH);
        end
    end

    // input may only stall with both stages occupied
    always @(negedge clk) begin
        if (!rst) begin
            if (!in_ready) begin
                check_field(cur_test, "items in flight while in_ready low", 2, in_flight);
            end
            if (in_valid && in_ready) in_flight++;
            if (out_valid && out_ready) in_flight--;
        end
    end

    task automatic compare_item(input string name, input int idx);
        int          base;
        logic [31:0] inst;
        base = idx * FIELDS;
        inst = stim_mem[base + F_INST][31:0];
        check_field(name, "rd", inst[11:7], rd);
        check_field(name, "rs1", inst[19:15], rs1);
        check_field(name, "rs2", inst[24:20], rs2);
        // execution fields carry no meaning for illegal encodings
        if (stim_mem[base + F_ILL] == 64'h0) begin
            check_field(name, "alu_op", stim_mem[base + F_ALU], alu_op);
            check_field(name, "word_op", stim_mem[base + F_WORD], word_op);
            check_field(name, "src1", stim_mem[base + F_SRC1], src1);
            check_field(name, "src2", stim_mem[base + F_SRC2], src2);
        end
        check_field(name, "br_cond", stim_mem[base + F_BR], br_cond);
        check_field(name, "jump", stim_mem[base + F_JUMP], jump);
        check_field(name, "load", stim_mem[base + F_LOAD], load);
        check_field(name, "store", stim_mem[base + F_STORE], store);
        // size and signedness only for memory accesses
        if (stim_mem[base + F_LOAD][0] || stim_mem[base + F_STORE][0]) begin
            check_field(name, "mem_size", stim_mem[base + F_SIZE], mem_size);
            check_field(name, "mem_unsigned", stim_mem[base + F_UNS], mem_unsigned);
        end
        check_field(name, "write_gpr", stim_mem[base + F_WGPR], write_gpr);
        check_field(name, "imm", stim_mem[base + F_IMM], imm);
        check_field(name, "illegal", stim_mem[base + F_ILL], illegal);
    endtask

    // ============================================================
    // stream driver and collector
    // ============================================================
    task automatic drive_items(input string name, input bit full_rate);
        int idx;
        int waited;
        for (idx = 0; idx < stim_count; idx++) begin
            in_valid = 1'b1;
            in_inst  = stim_mem[idx * FIELDS + F_INST][31:0];
            @(negedge clk);
            if (full_rate) begin
                check_field($sformatf("%s item %0d", name, idx), "in_ready", 1, in_ready);
            end
            waited = 0;
            while (!in_ready) begin
                waited++;
                if (waited > TIMEOUT) abort_run("timeout waiting for in_ready_o");
                @(negedge clk);
            end
            accept_q.push_back(cycle_cnt);
            expect_q.push_back(idx);
            @(posedge clk);
            #DRIVE_DELAY;
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_items(input string name, input bit full_rate);
        int    n;
        int    idx;
        int    waited;
        int    accepted_at;
        string item_name;
        for (n = 0; n < stim_count; n++) begin
            waited = 0;
            @(negedge clk);
            while (!(out_valid && out_ready)) begin
                waited++;
                if (waited > TIMEOUT) abort_run("timeout waiting for a decoded result");
                @(negedge clk);
            end
            if (expect_q.size() == 0) begin
                error_count++;
                $display("%s: a result left the decoder with no instruction pending", name);
            end else begin
                idx         = expect_q.pop_front();
                accepted_at = accept_q.pop_front();
                item_name   = $sformatf("%s item %0d", name, idx);
                if (full_rate) begin
                    check_field(item_name, "latency", 2, cycle_cnt - accepted_at);
                end
                compare_item(item_name, idx);
            end
        end
        // nothing duplicated behind the last result
        @(negedge clk);
        check_field(name, "out_valid after last result", 0, out_valid);
    endtask

    task automatic run_stream(input string name, input int mode);
        int errors_before;
        errors_before = error_count;
        @(negedge clk);
        cur_test   = name;
        ready_mode = mode;
        @(posedge clk);
        #DRIVE_DELAY;
        fork
            drive_items(name, mode == READY_HIGH);
            collect_items(name, mode == READY_HIGH);
        join
        test_count++;
        $display("test %s: %0d items, %0d errors", name, stim_count,
                 error_count - errors_before);
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        int i;
        int errors_before;
        in_valid  = 1'b0;
        in_inst   = '0;
        out_ready = 1'b0;
        rst       = 1'b1;
        for (i = 0; i < MAX_LINES * FIELDS; i++) begin
            stim_mem[i] = {~32'(i), 32'(i)};
        end
        $readmemh("tb/decode_stim.txt", stim_mem);
        while (stim_count < MAX_LINES && stim_mem[stim_count * FIELDS][63:32] == 32'h0) begin
            stim_count++;
        end
        if (stim_count == 0) abort_run("no stimulus lines read from tb/decode_stim.txt");

        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        errors_before = error_count;
        cur_test      = "reset_state";
        @(negedge clk);
        check_field(cur_test, "out_valid", 0, out_valid);
        check_field(cur_test, "in_ready", 1, in_ready);
        test_count++;
        $display("test reset_state: %0d errors", error_count - errors_before);

        run_stream("full_rate", READY_HIGH);
        run_stream("back_pressure", READY_LFSR);

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/decode_stim.txt
// inst alu_op word src1 src2 br_cond jump load store mem_size mem_unsigned write_gpr imm illegal
// exec columns unused on illegal lines, mem_size/mem_unsigned used for loads and stores only
// integer and m extension
ffb10093 00 0 0 1 0 0 0 0 0 0 1 fffffffffffffffb 0  // addi x1, x2, -5
06423193 03 0 0 1 0 0 0 0 0 0 1 0000000000000064 0  // sltiu x3, x4, 100
42135293 09 0 0 1 0 0 0 0 0 0 1 0000000000000421 0  // srai x5, x6, 33
409403b3 01 0 0 0 0 0 0 0 0 0 1 0000000000000000 0  // sub x7, x8, x9
40c5d53b 09 1 0 0 0 0 0 0 0 0 1 0000000000000000 0  // sraw x10, x11, x12
02f726b3 0c 0 0 0 0 0 0 0 0 0 1 0000000000000000 0  // mulhsu x13, x14, x15
0328d833 0f 0 0 0 0 0 0 0 0 0 1 0000000000000000 0  // divu x16, x17, x18
035a69bb 10 1 0 0 0 0 0 0 0 0 1 0000000000000000 0  // remw x19, x20, x21
80000b37 12 0 0 1 0 0 0 0 0 0 1 ffffffff80000000 0  // lui x22, 0x80000
12345b97 00 0 1 1 0 0 0 0 0 0 1 0000000012345000 0  // auipc x23, 0x12345
// branches, jumps, loads and stores
fe208ce3 01 0 0 0 1 1 0 0 0 0 0 fffffffffffffff8 0  // beq x1, x2, -8
0041f863 01 0 0 0 6 1 0 0 0 0 0 0000000000000010 0  // bgeu x3, x4, 16
ffdff0ef 00 0 1 2 0 1 0 0 0 0 1 fffffffffffffffc 0  // jal x1, -4
00c302e7 00 0 1 2 0 2 0 0 0 0 1 000000000000000c 0  // jalr x5, 12(x6)
fff44383 00 0 0 1 0 0 1 0 0 1 1 ffffffffffffffff 0  // lbu x7, -1(x8)
01053483 00 0 0 1 0 0 1 0 3 0 1 0000000000000010 0  // ld x9, 16(x10)
feb61d23 00 0 0 1 0 0 0 1 1 0 0 fffffffffffffffa 0  // sh x11, -6(x12)
02d73423 00 0 0 1 0 0 0 1 3 0 0 0000000000000028 0  // sd x13, 40(x14)
// illegal encodings
00000073 00 0 0 0 0 0 0 0 0 0 0 0000000000000000 1  // ecall
300110f3 00 0 0 0 0 0 0 0 0 0 0 0000000000000000 1  // csrrw x1, mstatus, x2
00100073 00 0 0 0 0 0 0 0 0 0 0 0000000000000000 1  // ebreak
00b5057f 00 0 0 0 0 0 0 0 0 0 0 0000000000000000 1  // unknown opcode 7f
209403b3 00 0 0 0 0 0 0 0 0 0 0 0000000000000000 1  // sub with func7 0x10

//--- filelist.f
+incdir+logic
logic/rv_decode_pkg.sv
logic/rv_inst_classifier.sv
logic/rv_exec_ctrl.sv
logic/rv_flow_mem_ctrl.sv
logic/rv_imm_gen.sv
logic/rv_pipe_reg.sv
logic/rv_decode_top.sv
tb/rv_decode_tb.sv
